/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module board_ctrl_tb -f list.f -Mdir obj_dir -o board_ctrl_sim
	./obj_dir/board_ctrl_sim > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -qF '*** FAILED ***' sim.log; then echo "test failed"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf obj_dir sim.log

/* design/axil_router.sv */
module axil_router (
  input  logic                 clk_wiz_refclk,
  input  logic                 rst_n,
  // from in_slice
  input  board_pkg::axil_req_t req,
  input  logic                 req_valid,
  output logic                 req_ready,
  // to out_slice
  output board_pkg::axil_rsp_t rsp,
  output logic                 rsp_valid,
  input  logic                 rsp_ready,
  // shared target request, one strobe per target
  output board_pkg::axil_req_t tgt_req,
  output logic                 scratch_req_valid,
  output logic                 clk_req_valid,
  // target responses, one cycle after the strobe
  input  board_pkg::axil_rsp_t scratch_rsp,
  input  logic                 scratch_rsp_valid,
  input  board_pkg::axil_rsp_t clk_rsp,
  input  logic                 clk_rsp_valid
);

  typedef enum logic [1:0] {
    S_IDLE,                                     // free, may pop a request
    S_WAIT,                                     // strobe sent, waiting on the target
    S_PUSH                                      // response held toward out_slice
  } state_t;

  state_t               state_q;
  board_pkg::axil_req_t req_q;                  // request in flight
  board_pkg::axil_rsp_t rsp_q;                  // captured target response
  logic                 scratch_req_valid_q;
  logic                 clk_req_valid_q;
  logic                 req_fire;
  logic                 sel_clk;                // decode of the incoming request
  logic                 held_clk;               // decode of the request in flight
  logic                 tgt_rsp_valid;
  board_pkg::axil_rsp_t tgt_rsp;

  // only one request outstanding, so idle is the only state that pops
  assign req_ready = (state_q == S_IDLE);
  assign req_fire  = req_valid & req_ready;
  assign sel_clk   = req.addr[board_pkg::TARGET_SEL_BIT];
  assign held_clk  = req_q.addr[board_pkg::TARGET_SEL_BIT];

  // listen only to the target that was addressed
  assign tgt_rsp_valid = held_clk ? clk_rsp_valid : scratch_rsp_valid;
  assign tgt_rsp       = held_clk ? clk_rsp : scratch_rsp;

  assign tgt_req           = req_q;
  assign scratch_req_valid = scratch_req_valid_q;
  assign clk_req_valid     = clk_req_valid_q;
  assign rsp               = rsp_q;
  assign rsp_valid         = (state_q == S_PUSH);

  always_ff @(posedge clk_wiz_refclk) begin
    if (!rst_n) begin
      state_q             <= S_IDLE;
      scratch_req_valid_q <= 1'b0;
      clk_req_valid_q     <= 1'b0;
    end else begin
      scratch_req_valid_q <= req_fire & ~sel_clk;    // one-cycle strobe on the pop edge
      clk_req_valid_q     <= req_fire & sel_clk;
      case (state_q)
        S_IDLE: begin
          if (req_fire) begin
            state_q <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (tgt_rsp_valid) begin
            state_q <= S_PUSH;
          end
        end
        S_PUSH: begin
          if (rsp_ready) begin
            state_q <= S_IDLE;                  // next pop no earlier than next cycle
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_wiz_refclk) begin
    if (req_fire) begin
      req_q <= req;
    end
    if ((state_q == S_WAIT) && tgt_rsp_valid) begin
      rsp_q <= tgt_rsp;                         // held until out_slice takes it
    end
  end

endmodule

/* design/axil_slice.sv */
module axil_slice #(
  parameter type payload_t = logic              // request or response struct
) (
  input  logic     clk_wiz_refclk,
  input  logic     rst_n,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  payload_t out_q;                              // entry driving the output
  payload_t skid_q;                             // overflow entry while output stalls
  logic     out_valid_q;
  logic     skid_valid_q;
  logic     in_fire;
  logic     out_free;                           // output entry empty or leaving this edge

  // ready only depends on a flop, so no comb path from out_ready back to in_ready
  assign in_ready  = ~skid_valid_q;
  assign in_fire   = in_valid & in_ready;
  assign out_free  = ~out_valid_q | out_ready;
  assign out_data  = out_q;
  assign out_valid = out_valid_q;

  always_ff @(posedge clk_wiz_refclk) begin
    if (!rst_n) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (out_free) begin
      out_valid_q  <= skid_valid_q | in_fire;   // skid drains first, else take input
      skid_valid_q <= 1'b0;
    end else if (in_fire) begin
      skid_valid_q <= 1'b1;                     // output stuck, park the new beat
    end
  end

  always_ff @(posedge clk_wiz_refclk) begin
    if (out_free && (skid_valid_q || in_fire)) begin
      out_q <= skid_valid_q ? skid_q : in_data; // in_fire is low while skid is full
    end
    if (!out_free && in_fire) begin
      skid_q <= in_data;
    end
  end

endmodule

/* design/board_ctrl_top.sv */
module board_ctrl_top #(
  parameter int REG_COUNT   = 8,                // scratch words
  parameter int SYNC_STAGES = 4                 // lock synchronizer depth
) (
  input  logic                 clk_wiz_refclk,
  input  logic                 rst_n,
  input  board_pkg::axil_req_t host_req,
  input  logic                 host_req_valid,
  output logic                 host_req_ready,
  output board_pkg::axil_rsp_t host_rsp,
  output logic                 host_rsp_valid,
  input  logic                 host_rsp_ready,
  input  logic                 clk_wiz_locked,
  output logic                 clk_wiz_reset,
  output logic                 fpga_top_resetn
);

  board_pkg::axil_req_t rtr_req;                // in_slice -> router
  logic                 rtr_req_valid;
  logic                 rtr_req_ready;
  board_pkg::axil_rsp_t rtr_rsp;                // router -> out_slice
  logic                 rtr_rsp_valid;
  logic                 rtr_rsp_ready;
  board_pkg::axil_req_t tgt_req;                // shared by both targets
  logic                 scratch_req_valid;
  logic                 clk_req_valid;
  board_pkg::axil_rsp_t scratch_rsp;
  logic                 scratch_rsp_valid;
  board_pkg::axil_rsp_t clk_rsp;
  logic                 clk_rsp_valid;

  axil_slice #(
    .payload_t (board_pkg::axil_req_t)
  ) in_slice (
    .clk_wiz_refclk,
    .rst_n,
    .in_data   (host_req),
    .in_valid  (host_req_valid),
    .in_ready  (host_req_ready),
    .out_data  (rtr_req),
    .out_valid (rtr_req_valid),
    .out_ready (rtr_req_ready)
  );

  axil_router u_router (
    .clk_wiz_refclk,
    .rst_n,
    .req               (rtr_req),
    .req_valid         (rtr_req_valid),
    .req_ready         (rtr_req_ready),
    .rsp               (rtr_rsp),
    .rsp_valid         (rtr_rsp_valid),
    .rsp_ready         (rtr_rsp_ready),
    .tgt_req,
    .scratch_req_valid,
    .clk_req_valid,
    .scratch_rsp,
    .scratch_rsp_valid,
    .clk_rsp,
    .clk_rsp_valid
  );

  axil_slice #(
    .payload_t (board_pkg::axil_rsp_t)
  ) out_slice (
    .clk_wiz_refclk,
    .rst_n,
    .in_data   (rtr_rsp),
    .in_valid  (rtr_rsp_valid),
    .in_ready  (rtr_rsp_ready),
    .out_data  (host_rsp),
    .out_valid (host_rsp_valid),
    .out_ready (host_rsp_ready)
  );

  scratch_regs #(
    .REG_COUNT (REG_COUNT)
  ) u_scratch (
    .clk_wiz_refclk,
    .rst_n,
    .req       (tgt_req),
    .req_valid (scratch_req_valid),
    .rsp       (scratch_rsp),
    .rsp_valid (scratch_rsp_valid)
  );

  clkwiz_ctrl_regs #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_clkwiz (
    .clk_wiz_refclk,
    .rst_n,
    .req             (tgt_req),
    .req_valid       (clk_req_valid),
    .rsp             (clk_rsp),
    .rsp_valid       (clk_rsp_valid),
    .clk_wiz_locked,
    .clk_wiz_reset,
    .fpga_top_resetn
  );

endmodule

/* design/board_pkg.sv */
package board_pkg;

  // bus widths
  localparam int unsigned ADDR_W = 32;            // request address width
  localparam int unsigned DATA_W = 32;            // register data width
  localparam int unsigned STRB_W = DATA_W / 8;    // one strobe per byte lane
  localparam int unsigned RESP_W = 2;             // axi-lite style response code

  // address map
  localparam int unsigned TARGET_SEL_BIT = 16;    // 0 = scratch bank, 1 = clock control

  // byte offsets inside the clock-control window, only bits below TARGET_SEL_BIT decode
  localparam logic [TARGET_SEL_BIT-1:0] CTRL_OFFSET   = 'h0;  // pll reset / user reset
  localparam logic [TARGET_SEL_BIT-1:0] STATUS_OFFSET = 'h4;  // synchronized lock, read only

  // response codes
  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'd0;
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'd2;

  // bundled aw/w/ar request, one beat per transfer
  typedef struct packed {
    logic              write;   // 1 = write, 0 = read
    logic [ADDR_W-1:0] addr;    // byte address
    logic [DATA_W-1:0] wdata;   // write data, don't care on reads
    logic [STRB_W-1:0] wstrb;   // byte enables, don't care on reads
  } axil_req_t;                 // 69 bits

  // bundled b/r response
  typedef struct packed {
    logic [DATA_W-1:0] rdata;   // read data, zero for writes
    logic [RESP_W-1:0] resp;    // RESP_OKAY or RESP_SLVERR
  } axil_rsp_t;                 // 34 bits

endpackage

/* design/clkwiz_ctrl_regs.sv */
module clkwiz_ctrl_regs #(
  parameter int SYNC_STAGES = 4                 // lock synchronizer depth, 2 or more
) (
  input  logic                 clk_wiz_refclk,
  input  logic                 rst_n,
  input  board_pkg::axil_req_t req,
  input  logic                 req_valid,
  output board_pkg::axil_rsp_t rsp,
  output logic                 rsp_valid,
  input  logic                 clk_wiz_locked,  // async level from the pll
  output logic                 clk_wiz_reset,
  output logic                 fpga_top_resetn
);

  localparam int OFF_W = board_pkg::TARGET_SEL_BIT;

  logic [SYNC_STAGES-1:0] lock_sync_q;          // stage 0 samples the async input
  logic                   lock_status;
  logic [1:0]             ctrl_q;               // bit 0 pll reset, bit 1 user resetn
  logic [OFF_W-1:0]       offset;
  logic                   hit_ctrl;
  logic                   hit_status;
  logic                   rsp_valid_q;
  board_pkg::axil_rsp_t   rsp_d;
  board_pkg::axil_rsp_t   rsp_q;

  assign offset      = req.addr[OFF_W-1:0];
  assign hit_ctrl    = (offset == board_pkg::CTRL_OFFSET);
  assign hit_status  = (offset == board_pkg::STATUS_OFFSET);
  assign lock_status = lock_sync_q[SYNC_STAGES-1];

  assign clk_wiz_reset   = ctrl_q[0];
  assign fpga_top_resetn = ctrl_q[1];           // user logic held in reset until set
  assign rsp             = rsp_q;
  assign rsp_valid       = rsp_valid_q;

  always_ff @(posedge clk_wiz_refclk) begin
    if (!rst_n) begin
      lock_sync_q <= '0;
      ctrl_q      <= 2'b00;
      rsp_valid_q <= 1'b0;
    end else begin
      lock_sync_q <= {lock_sync_q[SYNC_STAGES-2:0], clk_wiz_locked};
      rsp_valid_q <= req_valid;
      if (req_valid && req.write && hit_ctrl) begin
        ctrl_q <= req.wdata[1:0];               // strobes ignored here
      end
    end
  end

  // decode, bad offsets and status writes give slverr with zero data
  always_comb begin
    rsp_d       = '0;
    rsp_d.resp  = board_pkg::RESP_SLVERR;
    if (hit_ctrl) begin
      rsp_d.resp = board_pkg::RESP_OKAY;
      if (!req.write) begin
        rsp_d.rdata = {{(board_pkg::DATA_W-2){1'b0}}, ctrl_q};
      end
    end else if (hit_status && !req.write) begin
      rsp_d.resp  = board_pkg::RESP_OKAY;
      rsp_d.rdata = {{(board_pkg::DATA_W-1){1'b0}}, lock_status};
    end
  end

  always_ff @(posedge clk_wiz_refclk) begin
    if (req_valid) begin
      rsp_q <= rsp_d;
    end
  end

endmodule

/* design/scratch_regs.sv */
module scratch_regs #(
  parameter int REG_COUNT = 8                   // words, power of two
) (
  input  logic                 clk_wiz_refclk,
  input  logic                 rst_n,
  input  board_pkg::axil_req_t req,
  input  logic                 req_valid,
  output board_pkg::axil_rsp_t rsp,
  output logic                 rsp_valid
);

  localparam int OFF_W = $clog2(board_pkg::STRB_W);   // byte offset bits
  localparam int IDX_W = $clog2(REG_COUNT);

  logic [board_pkg::DATA_W-1:0] regs_q [REG_COUNT];
  logic [IDX_W-1:0]             idx;
  logic                         rsp_valid_q;
  board_pkg::axil_rsp_t         rsp_q;

  // bits above the word index are ignored, so the bank aliases
  assign idx       = req.addr[OFF_W +: IDX_W];
  assign rsp       = rsp_q;
  assign rsp_valid = rsp_valid_q;

  always_ff @(posedge clk_wiz_refclk) begin
    if (!rst_n) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
    end else if (req_valid && req.write) begin
      for (int b = 0; b < board_pkg::STRB_W; b++) begin
        if (req.wstrb[b]) begin
          regs_q[idx][8*b +: 8] <= req.wdata[8*b +: 8];   // byte merge
        end
      end
    end
  end

  always_ff @(posedge clk_wiz_refclk) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid;                 // fixed one-cycle answer
    end
  end

  always_ff @(posedge clk_wiz_refclk) begin
    if (req_valid) begin
      rsp_q.rdata <= req.write ? '0 : regs_q[idx];
      rsp_q.resp  <= board_pkg::RESP_OKAY;
    end
  end

endmodule

/* list.f */
design/board_pkg.sv
design/axil_slice.sv
design/axil_router.sv
design/scratch_regs.sv
design/clkwiz_ctrl_regs.sv
design/board_ctrl_top.sv
tb/board_ctrl_checker.sv
tb/board_ctrl_tb.sv

/* tb/board_ctrl_checker.sv */
module board_ctrl_checker (
  input logic                 clk_wiz_refclk,
  input logic                 rst_n,
  input board_pkg::axil_rsp_t host_rsp,
  input logic                 host_rsp_valid,
  input logic                 host_rsp_ready,
  input logic                 clk_wiz_reset,
  input logic                 fpga_top_resetn
);
  timeunit 1ns;
  timeprecision 1ps;

  // a stalled response keeps valid and payload until the host takes it
  rsp_hold: assert property (@(posedge clk_wiz_refclk) disable iff (!rst_n)
    host_rsp_valid && !host_rsp_ready |=> host_rsp_valid && $stable(host_rsp))
    else $error("host response changed or dropped while stalled");

  rst_ctrl_low: assert property (@(posedge clk_wiz_refclk)
    !rst_n |=> !clk_wiz_reset && !fpga_top_resetn)
    else $error("pll or user reset output high right after reset");

  rst_rsp_low: assert property (@(posedge clk_wiz_refclk)
    !rst_n |=> !host_rsp_valid)
    else $error("host_rsp_valid high right after reset");

endmodule

bind board_ctrl_top board_ctrl_checker u_checker (
  .clk_wiz_refclk  (clk_wiz_refclk),
  .rst_n           (rst_n),
  .host_rsp        (host_rsp),
  .host_rsp_valid  (host_rsp_valid),
  .host_rsp_ready  (host_rsp_ready),
  .clk_wiz_reset   (clk_wiz_reset),
  .fpga_top_resetn (fpga_top_resetn)
);

/* tb/board_ctrl_tb.sv */
module board_ctrl_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          REG_COUNT   = 8;
  localparam int          SYNC_STAGES = 4;
  localparam int          TIMEOUT     = 1000;   // cycles allowed per wait
  localparam int          RAND_REQS   = 300;
  localparam logic [31:0] SEED        = 32'hcd95;
  localparam logic [31:0] CTRL_ADDR   = {15'd0, 1'b1, board_pkg::CTRL_OFFSET};
  localparam logic [31:0] STATUS_ADDR = {15'd0, 1'b1, board_pkg::STATUS_OFFSET};

  logic                 clk_wiz_refclk;
  logic                 rst_n;
  board_pkg::axil_req_t host_req;
  logic                 host_req_valid;
  logic                 host_req_ready;
  board_pkg::axil_rsp_t host_rsp;
  logic                 host_rsp_valid;
  logic                 host_rsp_ready;
  logic                 clk_wiz_locked;
  logic                 clk_wiz_reset;
  logic                 fpga_top_resetn;

  integer               seed;                   // stimulus stream
  integer               ready_seed;             // host_rsp_ready stream
  logic [31:0]          ready_rnd;
  logic                 ready_random;           // toggle host_rsp_ready when set
  logic [31:0]          scratch_m [REG_COUNT] = '{default: '0};  // model of the bank
  logic [1:0]           ctrl_m = 2'b00;
  logic                 lock_m = 1'b0;
  board_pkg::axil_rsp_t exp_q [$];              // expected responses in request order
  board_pkg::axil_rsp_t mon_exp;
  int                   error_count   = 0;
  int                   timeout_count = 0;
  int                   req_count     = 0;
  int                   rsp_count     = 0;

  board_ctrl_top #(
    .REG_COUNT   (REG_COUNT),
    .SYNC_STAGES (SYNC_STAGES)
  ) u_board_ctrl_top (.*);

  initial begin
    clk_wiz_refclk = 1'b0;
    forever begin
      #20 clk_wiz_refclk = ~clk_wiz_refclk;    // 40 ns period
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
      error_count++;
    end
  endtask

  // register map model that returns the expected answer and updates its state
  function automatic board_pkg::axil_rsp_t model_access(input board_pkg::axil_req_t r);
    board_pkg::axil_rsp_t              rsp;
    logic [$clog2(REG_COUNT)-1:0]      word;
    logic [31:0]                       mask;
    logic [board_pkg::TARGET_SEL_BIT-1:0] off;
    rsp.rdata = '0;
    rsp.resp  = board_pkg::RESP_OKAY;
    word = r.addr[2 +: $clog2(REG_COUNT)];      // upper bits alias onto the bank
    off  = r.addr[board_pkg::TARGET_SEL_BIT-1:0];
    mask = {{8{r.wstrb[3]}}, {8{r.wstrb[2]}}, {8{r.wstrb[1]}}, {8{r.wstrb[0]}}};
    if (!r.addr[board_pkg::TARGET_SEL_BIT]) begin
      if (r.write) begin
        scratch_m[word] = (scratch_m[word] & ~mask) | (r.wdata & mask);
      end else begin
        rsp.rdata = scratch_m[word];
      end
    end else if (off == board_pkg::CTRL_OFFSET) begin
      if (r.write) begin
        ctrl_m = r.wdata[1:0];                  // strobes don't matter here
      end else begin
        rsp.rdata = {30'd0, ctrl_m};
      end
    end else if (off == board_pkg::STATUS_OFFSET && !r.write) begin
      rsp.rdata = {31'd0, lock_m};
    end else begin
      rsp.resp = board_pkg::RESP_SLVERR;        // status write or unused offset
    end
    return rsp;
  endfunction

  function automatic board_pkg::axil_req_t rand_req(input logic only_scratch);
    board_pkg::axil_req_t r;
    logic [31:0]          pick;
    pick    = $random(seed);
    r.addr  = $random(seed);
    r.wdata = $random(seed);
    r.write = pick[0];
    r.wstrb = pick[4:1];
    if (only_scratch || pick[7:5] < 3'd5) begin
      r.addr[board_pkg::TARGET_SEL_BIT] = 1'b0;
    end else begin
      r.addr[board_pkg::TARGET_SEL_BIT] = 1'b1;
      case (pick[7:5])
        3'd5:    r.addr[15:0] = board_pkg::CTRL_OFFSET;
        3'd6:    r.addr[15:0] = board_pkg::STATUS_OFFSET;
        default: r.addr[3] = 1'b1;              // never 0x0 or 0x4
      endcase
    end
    return r;
  endfunction

  // holds the request from just after a rising edge until the DUT takes it
  task automatic issue(input board_pkg::axil_req_t r);
    int cnt;
    cnt = 0;
    host_req       <= r;
    host_req_valid <= 1'b1;
    @(posedge clk_wiz_refclk);
    while (!host_req_ready && cnt < TIMEOUT) begin
      @(posedge clk_wiz_refclk);
      cnt++;
    end
    if (host_req_ready) begin
      exp_q.push_back(model_access(r));         // transfer on this edge
      req_count++;
    end else begin
      $display("Timeout: host_req_ready stayed low for %0d cycles", TIMEOUT);
      timeout_count++;
    end
  endtask

  // drops valid and waits on falling edges until every response is back
  task automatic finish_burst();
    int cnt;
    cnt = 0;
    host_req_valid <= 1'b0;
    @(negedge clk_wiz_refclk);
    while (exp_q.size() != 0 && cnt < TIMEOUT) begin
      @(negedge clk_wiz_refclk);
      cnt++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout: %0d responses never came back", exp_q.size());
      timeout_count++;
      exp_q.delete();
    end
  endtask

  initial begin
    ready_seed     = SEED;
    host_rsp_ready <= 1'b0;
    forever begin
      @(posedge clk_wiz_refclk);
      ready_rnd      = $random(ready_seed);
      host_rsp_ready <= ready_random ? ready_rnd[0] : 1'b1;
    end
  end

  // each host response transfer is compared with the oldest expectation
  initial begin
    forever begin
      @(posedge clk_wiz_refclk);
      if (rst_n && host_rsp_valid && host_rsp_ready) begin
        rsp_count++;
        if (exp_q.size() == 0) begin
          $display("Error: response %0d arrived with no request outstanding", rsp_count);
          error_count++;
        end else begin
          mon_exp = exp_q.pop_front();
          check_value($sformatf("rsp %0d rdata", rsp_count), mon_exp.rdata, host_rsp.rdata);
          check_value($sformatf("rsp %0d resp", rsp_count), 32'(mon_exp.resp),
                      32'(host_rsp.resp));
        end
      end
    end
  end

  initial begin
    board_pkg::axil_req_t r;
    logic [31:0]          rnd;
    seed           = SEED;
    rst_n          <= 1'b0;
    host_req       <= '0;
    host_req_valid <= 1'b0;
    clk_wiz_locked <= 1'b0;
    ready_random   <= 1'b0;
    repeat (10) @(posedge clk_wiz_refclk);
    rst_n <= 1'b1;
    @(negedge clk_wiz_refclk);
    check_value("reset clk_wiz_reset", 32'd0, 32'(clk_wiz_reset));
    check_value("reset fpga_top_resetn", 32'd0, 32'(fpga_top_resetn));
    check_value("reset host_rsp_valid", 32'd0, 32'(host_rsp_valid));
    check_value("reset host_req_ready", 32'd1, 32'(host_req_ready));
    @(posedge clk_wiz_refclk);
    issue({1'b0, CTRL_ADDR, 32'd0, 4'hf});      // control reads 0 after reset
    finish_burst();
    @(posedge clk_wiz_refclk);
    for (int i = 0; i < 32; i++) begin          // 16 writes and then 16 reads
      r       = rand_req(1'b1);
      r.write = (i < 16);
      issue(r);
    end
    finish_burst();
    repeat (4) begin
      @(posedge clk_wiz_refclk);
      rnd = $random(seed);
      issue({1'b1, CTRL_ADDR, 30'd0, rnd[1:0], rnd[7:4]});
      finish_burst();
      check_value("ctrl outputs", {30'd0, rnd[1:0]}, {30'd0, fpga_top_resetn, clk_wiz_reset});
      @(posedge clk_wiz_refclk);
      issue({1'b0, CTRL_ADDR, 32'd0, 4'hf});
      finish_burst();
    end
    repeat (4) begin
      @(posedge clk_wiz_refclk);
      lock_m         = ~lock_m;                  // alternate so both levels are read
      clk_wiz_locked <= lock_m;
      repeat (2 * SYNC_STAGES) @(posedge clk_wiz_refclk);
      issue({1'b0, STATUS_ADDR, 32'd0, 4'hf});
      finish_burst();
    end
    @(posedge clk_wiz_refclk);
    issue({1'b1, STATUS_ADDR, 32'hffff_ffff, 4'hf});   // status is read only
    issue({1'b0, CTRL_ADDR | 32'h8, 32'd0, 4'hf});
    issue({1'b1, CTRL_ADDR | 32'hc, 32'h1234_5678, 4'hf});
    finish_burst();
    @(posedge clk_wiz_refclk);
    ready_random <= 1'b1;                        // back-pressure from the host side
    repeat (RAND_REQS) issue(rand_req(1'b0));
    finish_burst();
    check_value("request/response count", req_count, rsp_count);
    $display("summary: %0d errors, %0d timeouts, %0d requests, %0d responses",
             error_count, timeout_count, req_count, rsp_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
